/* filelist.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/riscv_core.sv
tb/core_assert.sv
tb/tb_core.sv

/* run.sh */
#!/bin/sh
# Compile the core and testbench with Verilator, run, and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_core -f filelist.f -o tb_core_sim \
    && ./obj_dir/tb_core_sim | tee sim.log \
    && grep -q "^Finished with no errors$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb/tb_core.sv */
// Testbench for the RV32I core: cache models, random program, reference model and store checks
`timescale 1ns/100ps
`default_nettype none

module tb_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam logic [31:0] RESET_PC     = 32'h0000_1000;
    localparam int          RAND_LEN     = 200;             // Random part of the program
    localparam int          PROG_LEN     = RAND_LEN + 31;   // Plus the dump of x1..x31
    localparam int          DMEM_WORDS   = 128;
    localparam int          DUMP_BASE    = 256;             // Byte address of the register dump
    localparam int          RESET_CYCLES = 8;
    localparam int          KIND_LW      = 14;
    localparam int          KIND_SW      = 15;

    // Kinds 0..5 are add sub and or xor slt, 6..13 are addi andi ori xori slti slli srli srai

    logic        clk;
    logic        RST_n;
    logic        icache_stall;
    logic        dcache_stall;
    logic [31:0] icache_rdata;
    logic [31:0] dcache_rdata;
    icache_req_t icache;
    dcache_req_t dcache;
    logic [31:0] pc;

    logic [31:0] rng_state;
    logic [31:0] prog_word [PROG_LEN];
    int          p_kind    [PROG_LEN];
    int          p_rd      [PROG_LEN];
    int          p_rs1     [PROG_LEN];
    int          p_rs2     [PROG_LEN];
    logic [31:0] p_imm     [PROG_LEN];
    int          n_inst;
    logic [31:0] dmem      [DMEM_WORDS];   // Data cache contents, little-endian words
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_count;
    int          store_cnt;
    int          errors;
    int          checks;
    int          cycle;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic [31:0] fetch_off;
    int          fetch_idx;

    riscv_core #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk          (clk),
        .RST_n        (RST_n),
        .icache_stall (icache_stall),
        .dcache_stall (dcache_stall),
        .icache_rdata (icache_rdata),
        .dcache_rdata (dcache_rdata),
        .icache       (icache),
        .dcache       (dcache),
        .pc           (pc)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int unsigned rnd_below(int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return (r >> 16) % n;   // Upper bits are less regular
    endfunction

    function automatic logic [31:0] byte_swap(logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] fill_word(int a);
        return 32'(a) * 32'h9E37_79B1 ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] encode(int kind, int rd, int rs1, int rs2, logic [31:0] imm);
        logic [2:0] f3;
        logic [4:0] d;
        logic [4:0] s1;
        logic [4:0] s2;
        d  = 5'(rd);
        s1 = 5'(rs1);
        s2 = 5'(rs2);
        case (kind)
            0, 1, 6: f3 = 3'b000;
            2, 7:    f3 = 3'b111;
            3, 8:    f3 = 3'b110;
            4, 9:    f3 = 3'b100;
            5, 10:   f3 = 3'b010;
            11:      f3 = 3'b001;
            12, 13:  f3 = 3'b101;
            default: f3 = 3'b010;   // lw, sw
        endcase
        if (kind <= 5)
            return {((kind == 1) ? 7'h20 : 7'h00), s2, s1, f3, d, opc_op};
        else if (kind == 13)
            return {7'h20, imm[4:0], s1, f3, d, opc_op_imm};
        else if (kind <= 12)
            return {imm[11:0], s1, f3, d, opc_op_imm};
        else if (kind == KIND_LW)
            return {imm[11:0], s1, f3, d, opc_load};
        else
            return {imm[11:5], s2, s1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] alu_model(int kind, logic [31:0] a, logic [31:0] b);
        case (kind)
            0, 6:    return a + b;
            1:       return a - b;
            2, 7:    return a & b;
            3, 8:    return a | b;
            4, 9:    return a ^ b;
            5, 10:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            11:      return a << b[4:0];
            12:      return a >> b[4:0];
            13:      return $signed(a) >>> b[4:0];
            default: return 32'd0;
        endcase
    endfunction

    task automatic add_inst(int kind, int rd, int rs1, int rs2, logic [31:0] imm);
        p_kind[n_inst]    = kind;
        p_rd[n_inst]      = rd;
        p_rs1[n_inst]     = rs1;
        p_rs2[n_inst]     = rs2;
        p_imm[n_inst]     = imm;
        prog_word[n_inst] = encode(kind, rd, rs1, rs2, imm);
        n_inst++;
    endtask

    // Registers come from x0..x7 so that dependencies are dense
    task automatic build_program();
        int          kind;
        int          sel;
        int          rd;
        int          rs1;
        int          rs2;
        logic [31:0] r;
        logic [31:0] imm;
        n_inst = 0;
        for (int i = 0; i < RAND_LEN; i++) begin
            sel = int'(rnd_below(10));
            if (sel < 2)
                kind = KIND_LW;
            else if (sel < 4)
                kind = KIND_SW;
            else
                kind = int'(rnd_below(14));
            rd  = int'(rnd_below(8));
            rs1 = int'(rnd_below(8));
            rs2 = int'(rnd_below(8));
            r   = next_rand();
            if (kind >= KIND_LW) begin
                rs1 = 0;                            // Absolute address off x0
                imm = {24'd0, r[21:16], 2'b00};
            end else if (kind >= 11) begin
                imm = {27'd0, r[20:16]};            // Shift amount
            end else begin
                imm = {{20{r[27]}}, r[27:16]};
            end
            add_inst(kind, rd, rs1, rs2, imm);
        end
        for (int i = 1; i < 32; i++) begin
            add_inst(KIND_SW, 0, 0, i, 32'(DUMP_BASE + 4 * i));
        end
    endtask

    // Sequential execution of the same program
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < n_inst; i++) begin
            a    = regs[p_rs1[i]];
            addr = a + p_imm[i];
            if (p_kind[i] == KIND_SW) begin
                model_mem[int'(addr[8:2])] = regs[p_rs2[i]];
                exp_addr.push_back(addr);
                exp_data.push_back(regs[p_rs2[i]]);
            end else begin
                if (p_kind[i] == KIND_LW) begin
                    res = model_mem[int'(addr[8:2])];
                end else begin
                    b   = (p_kind[i] <= 5) ? regs[p_rs2[i]] : p_imm[i];
                    res = alu_model(p_kind[i], a, b);
                end
                if (p_rd[i] != 0)
                    regs[p_rd[i]] = res;            // x0 stays zero
            end
        end
        exp_count = exp_addr.size();
    endtask

    task automatic check_value(string name, int idx, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error: %s %0d expected %h actual %h", name, idx, expected, actual);
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d, stores: %0d of %0d",
                 checks, errors, store_cnt, exp_count);
    endtask

    // Both caches answer for the address held since the last edge
    task automatic drive_caches();
        fetch_off = {icache.addr, 2'b00} - RESET_PC;
        fetch_idx = int'(fetch_off >> 2);
        if (fetch_off < 32'(PROG_LEN * 4))
            icache_rdata = byte_swap(prog_word[fetch_idx]);
        else
            icache_rdata = byte_swap(NOP_INST);    // Past the program
        if (dcache.ren)
            dcache_rdata = byte_swap(dmem[int'(dcache.addr[6:0])]);
        else
            dcache_rdata = '0;                      // No read requested
    endtask

    initial begin : stimulus
        clk          = 1'b0;
        RST_n        = 1'b0;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        icache_rdata = byte_swap(NOP_INST);
        dcache_rdata = '0;
        rng_state    = 32'ha5c8;
        errors       = 0;
        checks       = 0;
        store_cnt    = 0;
        cycle        = 0;
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a]      = fill_word(a);
            model_mem[a] = fill_word(a);
        end
        build_program();
        run_model();
        forever begin
            @(posedge clk);
            #2;
            cycle++;
            if (cycle == RESET_CYCLES)
                RST_n = 1'b1;
            if (RST_n) begin
                icache_stall = (rnd_below(8) == 0);   // About one cycle in eight
                dcache_stall = (rnd_below(8) == 0);
            end
            drive_caches();
        end
    end

    // A store commits at the next edge when no stall is raised
    always @(negedge clk) begin
        if (RST_n && dcache.wen && !(icache_stall || dcache_stall)) begin
            st_addr = {dcache.addr, 2'b00};
            st_data = byte_swap(dcache.wdata);
            assert (store_cnt < exp_count) else begin
                errors++;
                $display("Store to %h arrived after all %0d expected stores", st_addr, exp_count);
            end
            if (store_cnt < exp_count) begin
                check_value("store address", store_cnt, exp_addr[store_cnt], st_addr);
                check_value("store data", store_cnt, exp_data[store_cnt], st_data);
            end
            dmem[int'(st_addr[8:2])] = st_data;
            store_cnt++;
        end
    end

    initial begin : results
        wait (RST_n === 1'b1);
        #1;
        check_value("pc after reset", 0, RESET_PC, pc);
        wait (store_cnt == exp_count);
        repeat (20) @(posedge clk);                 // Room for a stray extra store
        for (int a = 0; a < DMEM_WORDS; a++) begin
            check_value("memory word", a, model_mem[a], dmem[a]);
        end
        print_summary();
        if (errors == 0 && store_cnt == exp_count) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + PROG_LEN * 8) @(posedge clk);
        $display("Timeout: the program did not complete its stores in time");
        print_summary();
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/core_assert.sv */
// Bound checks on the core's cache request ports and program counter
`timescale 1ns/100ps
`default_nettype none

module core_assert (
    input logic                  clk,
    input logic                  RST_n,
    input logic                  icache_stall,
    input logic                  dcache_stall,
    input pipe_pkg::icache_req_t icache,
    input pipe_pkg::dcache_req_t dcache,
    input logic [31:0]           pc
);
    logic stall;

    assign stall = icache_stall | dcache_stall;

    // One D-cache access at a time
    wen_ren_excl: assert property (@(posedge clk) disable iff (!RST_n)
        !(dcache.wen && dcache.ren))
        else $error("D-cache read and write requested in the same cycle");

    // Bus quiet after a reset edge
    reset_quiet: assert property (@(posedge clk)
        !RST_n |=> (!dcache.wen && !dcache.ren && icache.ren))
        else $error("Cache request not in its reset state after a reset edge");

    pc_hold: assert property (@(posedge clk) disable iff (!RST_n)
        stall |=> $stable(pc))
        else $error("PC moved during a cache stall");

endmodule

bind riscv_core core_assert u_core_assert (
    .clk          (clk),
    .RST_n        (RST_n),
    .icache_stall (icache_stall),
    .dcache_stall (dcache_stall),
    .icache       (icache),
    .dcache       (dcache),
    .pc           (pc)
);

`default_nettype wire

/* design/riscv_core.sv */
// RV32I five-stage core top level: stage wiring and the global cache stall
`timescale 1ns/100ps
`default_nettype none

module riscv_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  RST_n,
    input  logic                  icache_stall,
    input  logic                  dcache_stall,
    input  logic [31:0]           icache_rdata,
    input  logic [31:0]           dcache_rdata,
    output pipe_pkg::icache_req_t icache,
    output pipe_pkg::dcache_req_t dcache,
    output logic [31:0]           pc
);
    import pipe_pkg::*;

    logic        stall;
    logic        hazard;
    logic [31:0] inst;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_t         wb;

    assign stall = icache_stall | dcache_stall;  // Either cache freezes the whole pipe

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .RST_n        (RST_n),
        .stall        (stall),
        .hazard       (hazard),
        .icache_rdata (icache_rdata),
        .icache       (icache),
        .pc           (pc),
        .inst         (inst)
    );

    decode_stage u_decode (
        .clk    (clk),
        .RST_n  (RST_n),
        .stall  (stall),
        .inst   (inst),
        .wb     (wb),
        .id_ex  (id_ex),
        .hazard (hazard)
    );

    execute_stage u_execute (
        .clk    (clk),
        .RST_n  (RST_n),
        .stall  (stall),
        .id_ex  (id_ex),
        .wb     (wb),
        .ex_mem (ex_mem)
    );

    mem_stage u_mem (
        .clk          (clk),
        .RST_n        (RST_n),
        .stall        (stall),
        .ex_mem       (ex_mem),
        .dcache_rdata (dcache_rdata),
        .dcache       (dcache),
        .wb           (wb)
    );

endmodule

`default_nettype wire

/* design/mem_stage.sv */
// Memory access: D-cache request with byte swap and the MEM/WB register
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  logic                  clk,
    input  logic                  RST_n,
    input  logic                  stall,
    input  pipe_pkg::ex_mem_t     ex_mem,
    input  logic [31:0]           dcache_rdata,
    output pipe_pkg::dcache_req_t dcache,
    output pipe_pkg::wb_t         wb
);
    import isa_pkg::*;

    logic [XLEN-1:0] load_data;

    assign load_data = {<<8{dcache_rdata}};   // Back to little-endian

    always_comb begin
        dcache.ren   = ex_mem.mem_to_reg;     // Loads only
        dcache.wen   = ex_mem.mem_write;
        dcache.addr  = ex_mem.result[XLEN-1:2];
        dcache.wdata = {<<8{ex_mem.store_data}};
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            wb <= '0;
        end else if (!stall) begin
            wb.rd        <= ex_mem.rd;
            wb.reg_write <= ex_mem.reg_write;
            wb.data      <= ex_mem.mem_to_reg ? load_data : ex_mem.result;
        end
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// Execute: operand forwarding, ALU and the EX/MEM register
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              RST_n,
    input  logic              stall,
    input  pipe_pkg::id_ex_t  id_ex,
    input  pipe_pkg::wb_t     wb,
    output pipe_pkg::ex_mem_t ex_mem
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] alu_out;

    // Nearest producer wins; x0 is never forwarded
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       id_val,
        input ex_mem_t               near,
        input wb_t                   far
    );
        logic [XLEN-1:0] val;
        val = id_val;
        if (addr != '0) begin
            if (near.reg_write && near.rd == addr)
                val = near.result;
            else if (far.reg_write && far.rd == addr)
                val = far.data;
        end
        return val;
    endfunction

    always_comb begin
        op1     = forward(id_ex.rs1_addr, id_ex.rs1_data, ex_mem, wb);
        rs2_fwd = forward(id_ex.rs2_addr, id_ex.rs2_data, ex_mem, wb);
        op2     = id_ex.alu_src ? id_ex.imm : rs2_fwd;
    end

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_out = op1 + op2;
            alu_sub: alu_out = op1 - op2;
            alu_sll: alu_out = op1 << op2[4:0];
            alu_slt: alu_out = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_xor: alu_out = op1 ^ op2;
            alu_srl: alu_out = op1 >> op2[4:0];
            alu_sra: alu_out = $signed(op1) >>> op2[4:0];
            alu_or:  alu_out = op1 | op2;
            alu_and: alu_out = op1 & op2;
            default: alu_out = op1 + op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem.result     <= alu_out;
            ex_mem.store_data <= rs2_fwd;   // Forwarded value for sw
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.mem_write  <= id_ex.mem_write;
        end
    end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// Instruction decode: control and immediates, load-use detection and the ID/EX register
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic             clk,
    input  logic             RST_n,
    input  logic             stall,
    input  logic [31:0]      inst,
    input  pipe_pkg::wb_t    wb,
    output pipe_pkg::id_ex_t id_ex,
    output logic             hazard
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e               opc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_sh;
    logic                  is_shift;
    logic                  uses_rs2;
    id_ex_t                dec;

    assign opc      = opcode_e'(inst[6:0]);
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_sh = {27'd0, inst[24:20]};              // shamt only

    assign is_shift = (inst[13:12] == 2'b01);          // funct3 001 or 101
    assign uses_rs2 = (opc == opc_op) || (opc == opc_store);

    reg_file u_reg_file (
        .clk      (clk),
        .RST_n    (RST_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        dec          = '0;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rs1_addr = rs1_addr;
        dec.rs2_addr = rs2_addr;
        dec.rd       = inst[11:7];
        case (opc)
            opc_op: begin
                dec.alu_op    = alu_op_e'({inst[30], inst[14:12]});
                dec.reg_write = 1'b1;
            end
            opc_op_imm: begin
                dec.alu_src   = 1'b1;
                dec.reg_write = 1'b1;
                if (is_shift) begin
                    dec.imm    = imm_sh;
                    dec.alu_op = alu_op_e'({inst[30], inst[14:12]});  // srai sets bit 30
                end else begin
                    dec.imm    = imm_i;
                    dec.alu_op = alu_op_e'({1'b0, inst[14:12]});
                end
            end
            opc_load: begin
                dec.alu_src    = 1'b1;
                dec.reg_write  = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.is_load    = 1'b1;
                dec.imm        = imm_i;
                dec.alu_op     = alu_add;   // Address calculation
            end
            opc_store: begin
                dec.alu_src   = 1'b1;
                dec.mem_write = 1'b1;
                dec.imm       = imm_s;
                dec.alu_op    = alu_add;
            end
            default: begin
                dec.reg_write = 1'b0;       // Unsupported opcode retires as a no-op
            end
        endcase
    end

    // Load in ID/EX whose result the instruction in decode needs
    assign hazard = id_ex.is_load && (id_ex.rd != '0) &&
                    ((id_ex.rd == rs1_addr) || (uses_rs2 && id_ex.rd == rs2_addr));

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= hazard ? '0 : dec;     // Bubble carries no writes
        end
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
// Register file: 32 x 32-bit, x0 fixed at zero, write-through on read
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic          clk,
    input  logic          RST_n,
    input  logic [4:0]    rs1_addr,
    input  logic [4:0]    rs2_addr,
    input  pipe_pkg::wb_t wb,
    output logic [31:0]   rs1_data,
    output logic [31:0]   rs2_data
);
    import isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_en;

    assign wr_en = wb.reg_write && (wb.rd != '0);  // x0 never written

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write is visible to decode
    assign rs1_data = (wr_en && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
    assign rs2_data = (wr_en && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
// Instruction fetch: PC register, I-cache request and the IF/ID instruction register
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  RST_n,
    input  logic                  stall,
    input  logic                  hazard,
    input  logic [31:0]           icache_rdata,
    output pipe_pkg::icache_req_t icache,
    output logic [31:0]           pc,
    output logic [31:0]           inst
);
    import isa_pkg::*;

    logic hold;

    assign hold = stall | hazard;  // Cache freeze or load-use bubble

    always_comb begin
        icache.ren  = 1'b1;           // Fetch every cycle
        icache.addr = pc[XLEN-1:2];
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            pc   <= RESET_PC;
            inst <= NOP_INST;
        end else if (!hold) begin
            pc   <= pc + 32'd4;               // No control transfer
            inst <= {<<8{icache_rdata}};      // Big-endian bus to little-endian
        end
    end

endmodule

`default_nettype wire

/* design/pipe_pkg.sv */
// Pipeline structures: stage registers and the instruction and data cache buses
`default_nettype none

package pipe_pkg;

    // Instruction cache request
    typedef struct packed {
        logic        ren;
        logic [29:0] addr;   // Word address
    } icache_req_t;

    // Data cache request
    typedef struct packed {
        logic                        ren;
        logic                        wen;
        logic [29:0]                 addr;   // Word address
        logic [isa_pkg::XLEN-1:0]    wdata;  // Big-endian on the bus
    } dcache_req_t;

    // Decode to execute
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]       rs1_data;
        logic [isa_pkg::XLEN-1:0]       rs2_data;
        logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       imm;
        isa_pkg::alu_op_e               alu_op;
        logic                           alu_src;     // Immediate as operand 2
        logic                           reg_write;
        logic                           mem_to_reg;
        logic                           mem_write;
        logic                           is_load;     // For load-use detection
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]       result;
        logic [isa_pkg::XLEN-1:0]       store_data;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           reg_write;
        logic                           mem_to_reg;
        logic                           mem_write;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           reg_write;
        logic [isa_pkg::XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

/* design/isa_pkg.sv */
// RV32I instruction-set definitions: opcodes, ALU operations, widths and the NOP word
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;  // Data path width
    localparam int REG_ADDR_W = 5;   // Register index width

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // R-type ALU
        opc_op_imm = 7'b0010011,  // I-type ALU
        opc_load   = 7'b0000011,  // lw
        opc_store  = 7'b0100011   // sw
    } opcode_e;

    // Low three bits mirror funct3 and bit 3 mirrors inst[30],
    // so the decoder can build the code straight from the instruction
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_slt = 4'b0010,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

endpackage

`default_nettype wire
